/* hw/rv_pkg.sv */
package rv_pkg;

   localparam int XLEN   = 32;
   localparam int REG_AW = 5;

   typedef logic [XLEN-1:0]   word_t;
   typedef logic [REG_AW-1:0] reg_addr_t;

   // Only the major opcodes the core still executes
   typedef enum logic [6:0] {
      OP     = 7'b0110011,
      OP_IMM = 7'b0010011,
      LOAD   = 7'b0000011,
      STORE  = 7'b0100011,
      BRANCH = 7'b1100011
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4
   } alu_op_e;

   localparam word_t INSN_NOP = 32'h0000_0013;   // ADDI x0,x0,0

endpackage

/* hw/rv_fetch.sv */
`timescale 1ns/1ps

module rv_fetch
   import rv_pkg::*;
#(
   parameter word_t RESET_PC = '0
) (
   input  logic  clk,
   input  logic  rst_n_i,
   input  word_t inst_i,
   input  logic  stall_i,
   input  logic  branch_taken_i,
   input  word_t branch_target_i,
   output word_t inst_addr_o,
   output logic  inst_ce_o,
   output word_t if_id_insn_o,
   output word_t if_id_pc_o
);

   logic  ce_q;
   word_t pc_q;

   assign inst_addr_o = pc_q;
   assign inst_ce_o   = ce_q;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ce_q <= 1'b0;
         pc_q <= RESET_PC;
      end else begin
         ce_q <= 1'b1;                               // Fetch starts after release
         if (branch_taken_i) begin
            pc_q <= branch_target_i;
         end else if (ce_q && !stall_i) begin
            pc_q <= pc_q + 32'd4;
         end
      end
   end

   // IF/ID instruction, flushed to a bubble on a taken branch
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         if_id_insn_o <= INSN_NOP;
      end else if (branch_taken_i) begin
         if_id_insn_o <= INSN_NOP;
      end else if (!stall_i) begin
         if_id_insn_o <= ce_q ? inst_i : INSN_NOP;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall_i) begin
         if_id_pc_o <= pc_q;                         // Payload only
      end
   end

endmodule

/* hw/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile
   import rv_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n_i,
   input  reg_addr_t rs1_addr_i,
   input  reg_addr_t rs2_addr_i,
   input  logic      wr_en_i,
   input  reg_addr_t wr_addr_i,
   input  word_t     wr_data_i,
   output word_t     rs1_data_o,
   output word_t     rs2_data_o
);

   word_t regs [2**REG_AW];

   // x0 reads zero, a write in the same cycle is passed straight through
   function automatic word_t read_port(reg_addr_t addr);
      if (addr == '0) begin
         return '0;
      end else if (wr_en_i && (wr_addr_i == addr)) begin
         return wr_data_i;
      end
      return regs[addr];
   endfunction

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < 2**REG_AW; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en_i && (wr_addr_i != '0)) begin
         regs[wr_addr_i] <= wr_data_i;
      end
   end

   assign rs1_data_o = read_port(rs1_addr_i);
   assign rs2_data_o = read_port(rs2_addr_i);

endmodule

/* hw/rv_decode.sv */
`timescale 1ns/1ps

module rv_decode
   import rv_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n_i,
   input  word_t     if_id_insn_i,
   input  word_t     if_id_pc_i,
   input  word_t     rs1_data_i,
   input  word_t     rs2_data_i,
   input  logic      branch_taken_i,
   output reg_addr_t rs1_addr_o,
   output reg_addr_t rs2_addr_o,
   output logic      stall_o,
   output word_t     id_ex_pc_o,
   output word_t     id_ex_rs1_data_o,
   output word_t     id_ex_rs2_data_o,
   output word_t     id_ex_imm_o,
   output reg_addr_t id_ex_rs1_o,
   output reg_addr_t id_ex_rs2_o,
   output reg_addr_t id_ex_rd_o,
   output alu_op_e   id_ex_alu_op_o,
   output logic      id_ex_alu_src_o,
   output logic      id_ex_mem_read_o,
   output logic      id_ex_mem_write_o,
   output logic      id_ex_reg_write_o,
   output logic      id_ex_branch_o
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   reg_addr_t  rd;
   logic       dec_ok;
   alu_op_e    dec_alu_op;
   logic       dec_alu_src, dec_mem_read, dec_mem_write, dec_reg_write, dec_branch;
   word_t      dec_imm;

   assign opcode     = if_id_insn_i[6:0];
   assign rd         = if_id_insn_i[11:7];
   assign funct3     = if_id_insn_i[14:12];
   assign funct7     = if_id_insn_i[31:25];
   assign rs1_addr_o = if_id_insn_i[19:15];
   assign rs2_addr_o = if_id_insn_i[24:20];

   always_comb begin
      dec_ok        = 1'b1;
      dec_alu_op    = ALU_ADD;
      dec_alu_src   = 1'b0;
      dec_mem_read  = 1'b0;
      dec_mem_write = 1'b0;
      dec_reg_write = 1'b0;
      dec_branch    = 1'b0;
      dec_imm       = {{20{if_id_insn_i[31]}}, if_id_insn_i[31:20]};   // I-type
      case (opcode)
         OP: begin
            dec_reg_write = 1'b1;
            dec_ok = (funct7 == 7'h00) || ((funct7 == 7'h20) && (funct3 == 3'b000));
            case (funct3)
               3'b000:  dec_alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
               3'b100:  dec_alu_op = ALU_XOR;
               3'b110:  dec_alu_op = ALU_OR;
               3'b111:  dec_alu_op = ALU_AND;
               default: dec_ok = 1'b0;
            endcase
         end
         OP_IMM: begin
            dec_reg_write = 1'b1;
            dec_alu_src   = 1'b1;
            dec_ok        = (funct3 == 3'b000);              // ADDI only
         end
         LOAD: begin
            dec_reg_write = 1'b1;
            dec_alu_src   = 1'b1;
            dec_mem_read  = 1'b1;
            dec_ok        = (funct3 == 3'b010);              // Word loads
         end
         STORE: begin
            dec_alu_src   = 1'b1;
            dec_mem_write = 1'b1;
            dec_ok        = (funct3 == 3'b010);
            dec_imm = {{20{if_id_insn_i[31]}}, if_id_insn_i[31:25], if_id_insn_i[11:7]};
         end
         BRANCH: begin
            dec_branch = 1'b1;
            dec_ok     = (funct3 == 3'b000);                 // BEQ only
            dec_imm = {{19{if_id_insn_i[31]}}, if_id_insn_i[31], if_id_insn_i[7],
                       if_id_insn_i[30:25], if_id_insn_i[11:8], 1'b0};
         end
         default: dec_ok = 1'b0;
      endcase
   end

   // Load in EX whose result the decoding instruction needs
   assign stall_o = id_ex_mem_read_o && (id_ex_rd_o != '0) &&
                    ((id_ex_rd_o == rs1_addr_o) || (id_ex_rd_o == rs2_addr_o));

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         id_ex_rs1_o       <= '0;
         id_ex_rs2_o       <= '0;
         id_ex_rd_o        <= '0;
         id_ex_alu_op_o    <= ALU_ADD;
         id_ex_alu_src_o   <= 1'b0;
         id_ex_mem_read_o  <= 1'b0;
         id_ex_mem_write_o <= 1'b0;
         id_ex_reg_write_o <= 1'b0;
         id_ex_branch_o    <= 1'b0;
      end else if (branch_taken_i || stall_o || !dec_ok) begin
         id_ex_rs1_o       <= '0;                      // Bubble
         id_ex_rs2_o       <= '0;
         id_ex_rd_o        <= '0;
         id_ex_alu_op_o    <= ALU_ADD;
         id_ex_alu_src_o   <= 1'b0;
         id_ex_mem_read_o  <= 1'b0;
         id_ex_mem_write_o <= 1'b0;
         id_ex_reg_write_o <= 1'b0;
         id_ex_branch_o    <= 1'b0;
      end else begin
         id_ex_rs1_o       <= rs1_addr_o;
         id_ex_rs2_o       <= rs2_addr_o;
         id_ex_rd_o        <= dec_reg_write ? rd : '0;
         id_ex_alu_op_o    <= dec_alu_op;
         id_ex_alu_src_o   <= dec_alu_src;
         id_ex_mem_read_o  <= dec_mem_read;
         id_ex_mem_write_o <= dec_mem_write;
         id_ex_reg_write_o <= dec_reg_write;
         id_ex_branch_o    <= dec_branch;
      end
   end

   always_ff @(posedge clk) begin
      id_ex_pc_o       <= if_id_pc_i;
      id_ex_rs1_data_o <= rs1_data_i;
      id_ex_rs2_data_o <= rs2_data_i;
      id_ex_imm_o      <= dec_imm;
   end

endmodule

/* hw/rv_execute.sv */
`timescale 1ns/1ps

module rv_execute
   import rv_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n_i,
   input  word_t     id_ex_pc_i,
   input  word_t     id_ex_rs1_data_i,
   input  word_t     id_ex_rs2_data_i,
   input  word_t     id_ex_imm_i,
   input  reg_addr_t id_ex_rs1_i,
   input  reg_addr_t id_ex_rs2_i,
   input  reg_addr_t id_ex_rd_i,
   input  alu_op_e   id_ex_alu_op_i,
   input  logic      id_ex_alu_src_i,
   input  logic      id_ex_mem_read_i,
   input  logic      id_ex_mem_write_i,
   input  logic      id_ex_reg_write_i,
   input  logic      id_ex_branch_i,
   input  logic      wb_en_i,
   input  reg_addr_t wb_addr_i,
   input  word_t     wb_data_i,
   output logic      branch_taken_o,
   output word_t     branch_target_o,
   output word_t     ex_mem_result_o,
   output word_t     ex_mem_store_data_o,
   output reg_addr_t ex_mem_rd_o,
   output logic      ex_mem_mem_read_o,
   output logic      ex_mem_mem_write_o,
   output logic      ex_mem_reg_write_o
);

   word_t op_a, op_b, rs2_fwd, alu_res;

   // EX/MEM wins over MEM/WB, x0 never forwarded
   function automatic word_t forward(reg_addr_t rs, word_t rf_val);
      if (rs == '0) begin
         return rf_val;
      end else if (ex_mem_reg_write_o && !ex_mem_mem_read_o && (ex_mem_rd_o == rs)) begin
         return ex_mem_result_o;
      end else if (wb_en_i && (wb_addr_i == rs)) begin
         return wb_data_i;
      end
      return rf_val;
   endfunction

   assign op_a    = forward(id_ex_rs1_i, id_ex_rs1_data_i);
   assign rs2_fwd = forward(id_ex_rs2_i, id_ex_rs2_data_i);
   assign op_b    = id_ex_alu_src_i ? id_ex_imm_i : rs2_fwd;

   always_comb begin
      case (id_ex_alu_op_i)
         ALU_SUB: alu_res = op_a - op_b;
         ALU_AND: alu_res = op_a & op_b;
         ALU_OR:  alu_res = op_a | op_b;
         ALU_XOR: alu_res = op_a ^ op_b;
         default: alu_res = op_a + op_b;              // Also load/store address
      endcase
   end

   assign branch_taken_o  = id_ex_branch_i && (op_a == rs2_fwd);   // BEQ
   assign branch_target_o = id_ex_pc_i + id_ex_imm_i;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ex_mem_rd_o        <= '0;
         ex_mem_mem_read_o  <= 1'b0;
         ex_mem_mem_write_o <= 1'b0;
         ex_mem_reg_write_o <= 1'b0;
      end else begin
         ex_mem_rd_o        <= id_ex_rd_i;
         ex_mem_mem_read_o  <= id_ex_mem_read_i;
         ex_mem_mem_write_o <= id_ex_mem_write_i;
         ex_mem_reg_write_o <= id_ex_reg_write_i;
      end
   end

   always_ff @(posedge clk) begin
      ex_mem_result_o     <= alu_res;
      ex_mem_store_data_o <= rs2_fwd;                 // Forwarded store data
   end

endmodule

/* hw/rv_mem_wb.sv */
`timescale 1ns/1ps

module rv_mem_wb
   import rv_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n_i,
   input  word_t     ex_mem_result_i,
   input  word_t     ex_mem_store_data_i,
   input  reg_addr_t ex_mem_rd_i,
   input  logic      ex_mem_mem_read_i,
   input  logic      ex_mem_mem_write_i,
   input  logic      ex_mem_reg_write_i,
   input  word_t     data_i,
   output word_t     data_addr_o,
   output word_t     data_o,
   output logic      data_we_o,
   output logic      data_ce_o,
   output logic      wb_en_o,
   output reg_addr_t wb_addr_o,
   output word_t     wb_data_o
);

   logic      wb_en_q;
   reg_addr_t wb_addr_q;
   word_t     wb_data_q;

   // Data port straight from EX/MEM
   assign data_addr_o = ex_mem_result_i;
   assign data_o      = ex_mem_store_data_i;
   assign data_we_o   = ex_mem_mem_write_i;
   assign data_ce_o   = ex_mem_mem_read_i | ex_mem_mem_write_i;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wb_en_q   <= 1'b0;
         wb_addr_q <= '0;
      end else begin
         wb_en_q   <= ex_mem_reg_write_i && (ex_mem_rd_i != '0);   // No x0 writes
         wb_addr_q <= ex_mem_rd_i;
      end
   end

   always_ff @(posedge clk) begin
      wb_data_q <= ex_mem_mem_read_i ? data_i : ex_mem_result_i;
   end

   assign wb_en_o   = wb_en_q;
   assign wb_addr_o = wb_addr_q;
   assign wb_data_o = wb_data_q;

endmodule

/* hw/rv_core.sv */
`timescale 1ns/1ps

module rv_core
   import rv_pkg::*;
#(
   parameter word_t RESET_PC = '0
) (
   input  logic  clk,
   input  logic  rst_n_i,
   input  word_t inst_i,
   input  word_t data_i,
   output word_t inst_addr_o,
   output logic  inst_ce_o,
   output word_t data_addr_o,
   output word_t data_o,
   output logic  data_we_o,
   output logic  data_ce_o
);

   word_t     if_id_insn, if_id_pc;
   logic      stall, branch_taken;
   word_t     branch_target;
   reg_addr_t rs1_addr, rs2_addr;
   word_t     rs1_data, rs2_data;
   word_t     id_ex_pc, id_ex_rs1_data, id_ex_rs2_data, id_ex_imm;
   reg_addr_t id_ex_rs1, id_ex_rs2, id_ex_rd;
   alu_op_e   id_ex_alu_op;
   logic      id_ex_alu_src, id_ex_mem_read, id_ex_mem_write;
   logic      id_ex_reg_write, id_ex_branch;
   word_t     ex_mem_result, ex_mem_store_data;
   reg_addr_t ex_mem_rd;
   logic      ex_mem_mem_read, ex_mem_mem_write, ex_mem_reg_write;
   logic      wb_en;
   reg_addr_t wb_addr;
   word_t     wb_data;

   rv_fetch #(.RESET_PC(RESET_PC)) u_fetch (
      .clk(clk), .rst_n_i(rst_n_i), .inst_i(inst_i), .stall_i(stall),
      .branch_taken_i(branch_taken), .branch_target_i(branch_target),
      .inst_addr_o(inst_addr_o), .inst_ce_o(inst_ce_o),
      .if_id_insn_o(if_id_insn), .if_id_pc_o(if_id_pc)
   );

   rv_decode u_decode (
      .clk(clk), .rst_n_i(rst_n_i), .if_id_insn_i(if_id_insn), .if_id_pc_i(if_id_pc),
      .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .branch_taken_i(branch_taken),
      .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr), .stall_o(stall),
      .id_ex_pc_o(id_ex_pc), .id_ex_rs1_data_o(id_ex_rs1_data),
      .id_ex_rs2_data_o(id_ex_rs2_data), .id_ex_imm_o(id_ex_imm),
      .id_ex_rs1_o(id_ex_rs1), .id_ex_rs2_o(id_ex_rs2), .id_ex_rd_o(id_ex_rd),
      .id_ex_alu_op_o(id_ex_alu_op), .id_ex_alu_src_o(id_ex_alu_src),
      .id_ex_mem_read_o(id_ex_mem_read), .id_ex_mem_write_o(id_ex_mem_write),
      .id_ex_reg_write_o(id_ex_reg_write), .id_ex_branch_o(id_ex_branch)
   );

   rv_regfile u_regfile (
      .clk(clk), .rst_n_i(rst_n_i), .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
      .wr_en_i(wb_en), .wr_addr_i(wb_addr), .wr_data_i(wb_data),
      .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
   );

   rv_execute u_execute (
      .clk(clk), .rst_n_i(rst_n_i), .id_ex_pc_i(id_ex_pc),
      .id_ex_rs1_data_i(id_ex_rs1_data), .id_ex_rs2_data_i(id_ex_rs2_data),
      .id_ex_imm_i(id_ex_imm), .id_ex_rs1_i(id_ex_rs1), .id_ex_rs2_i(id_ex_rs2),
      .id_ex_rd_i(id_ex_rd), .id_ex_alu_op_i(id_ex_alu_op),
      .id_ex_alu_src_i(id_ex_alu_src), .id_ex_mem_read_i(id_ex_mem_read),
      .id_ex_mem_write_i(id_ex_mem_write), .id_ex_reg_write_i(id_ex_reg_write),
      .id_ex_branch_i(id_ex_branch), .wb_en_i(wb_en), .wb_addr_i(wb_addr),
      .wb_data_i(wb_data), .branch_taken_o(branch_taken),
      .branch_target_o(branch_target), .ex_mem_result_o(ex_mem_result),
      .ex_mem_store_data_o(ex_mem_store_data), .ex_mem_rd_o(ex_mem_rd),
      .ex_mem_mem_read_o(ex_mem_mem_read), .ex_mem_mem_write_o(ex_mem_mem_write),
      .ex_mem_reg_write_o(ex_mem_reg_write)
   );

   rv_mem_wb u_mem_wb (
      .clk(clk), .rst_n_i(rst_n_i), .ex_mem_result_i(ex_mem_result),
      .ex_mem_store_data_i(ex_mem_store_data), .ex_mem_rd_i(ex_mem_rd),
      .ex_mem_mem_read_i(ex_mem_mem_read), .ex_mem_mem_write_i(ex_mem_mem_write),
      .ex_mem_reg_write_i(ex_mem_reg_write), .data_i(data_i),
      .data_addr_o(data_addr_o), .data_o(data_o), .data_we_o(data_we_o),
      .data_ce_o(data_ce_o), .wb_en_o(wb_en), .wb_addr_o(wb_addr), .wb_data_o(wb_data)
   );

endmodule

/* dv/rv_clk_gen.sv */
`timescale 1ns/1ps

module rv_clk_gen #(
   parameter int RESET_CYCLES = 4
) (
   input  logic restart_i,
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #5 clk_o = ~clk_o;                     // 10 ns period
   end

   // Reset at time zero and again on every restart request
   always begin
      rst_n_o <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      rst_n_o <= 1'b1;                               // Release away from the active edge
      @(posedge restart_i);
   end

endmodule

/* dv/rv_core_chk.sv */
`timescale 1ns/1ps

module rv_core_chk
   import rv_pkg::*;
(
   input logic  clk,
   input logic  rst_n_i,
   input word_t inst_addr_i,
   input logic  inst_ce_i,
   input logic  data_we_i,
   input logic  data_ce_i
);

   we_needs_ce: assert property (@(posedge clk) data_we_i |-> data_ce_i)
      else $error("Data write enable seen without data chip enable");

   // All port strobes quiet while the core is held in reset
   quiet_in_reset: assert property (@(posedge clk)
      !rst_n_i |-> !(inst_ce_i || data_ce_i || data_we_i))
      else $error("Port control active during reset");

   fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
      inst_ce_i |-> (inst_addr_i[1:0] == 2'b00))
      else $error("Instruction address not word aligned");

endmodule

bind rv_core rv_core_chk u_chk (
   .clk(clk), .rst_n_i(rst_n_i), .inst_addr_i(inst_addr_o), .inst_ce_i(inst_ce_o),
   .data_we_i(data_we_o), .data_ce_i(data_ce_o)
);

/* dv/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb
   import rv_pkg::*;
();

   localparam word_t RESET_PC  = 32'h0000_0100;
   localparam int    NUM_TESTS = 5;

   logic  clk, rst_n, restart;
   word_t inst_rdata, data_rdata;
   word_t inst_addr, data_addr, data_wdata;
   logic  inst_ce, data_we, data_ce;

   word_t imem [256];
   word_t dmem [256];
   word_t prog[$];
   word_t exp_addr[$], exp_data[$];
   word_t seen_addr[$], seen_data[$];
   word_t rng = 32'd12;

   rv_clk_gen u_clk_gen (.restart_i(restart), .clk_o(clk), .rst_n_o(rst_n));

   rv_core #(.RESET_PC(RESET_PC)) DUT (
      .clk(clk), .rst_n_i(rst_n), .inst_i(inst_rdata), .data_i(data_rdata),
      .inst_addr_o(inst_addr), .inst_ce_o(inst_ce), .data_addr_o(data_addr),
      .data_o(data_wdata), .data_we_o(data_we), .data_ce_o(data_ce)
   );

   task automatic abort_run(string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check(string name, word_t got, word_t exp);
      if (got !== exp) begin
         abort_run($sformatf("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp));
      end
   endtask

   function automatic word_t xorshift();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   function automatic reg_addr_t pick_reg(word_t r);
      return {2'b00, r[2:0] % 3'd7 + 3'd1};          // x1..x7
   endfunction

   function automatic word_t fill_word(int idx);
      word_t a;
      a = word_t'(idx) << 2;
      return 32'hA5C3_0000 ^ (a << 9) ^ a;
   endfunction

   function automatic word_t r_type(alu_op_e op, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
      logic [2:0] f3;
      logic [6:0] f7;
      f7 = 7'h00;
      case (op)
         ALU_SUB: begin
            f3 = 3'b000;
            f7 = 7'h20;
         end
         ALU_AND: f3 = 3'b111;
         ALU_OR:  f3 = 3'b110;
         ALU_XOR: f3 = 3'b100;
         default: f3 = 3'b000;
      endcase
      return {f7, rs2, rs1, f3, rd, OP};
   endfunction

   function automatic word_t i_type(opcode_e opc, reg_addr_t rd, reg_addr_t rs1,
                                    logic [11:0] imm);
      logic [2:0] f3;
      f3 = (opc == LOAD) ? 3'b010 : 3'b000;          // LW or ADDI
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic word_t s_type(reg_addr_t src, reg_addr_t base, logic [11:0] imm);
      return {imm[11:5], src, base, 3'b010, imm[4:0], STORE};
   endfunction

   function automatic word_t b_type(reg_addr_t rs1, reg_addr_t rs2, logic [12:0] imm);
      return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], BRANCH};
   endfunction

   // One cycle: record a store, then answer both memory ports
   task automatic step();
      @(negedge clk);
      if (data_ce && data_we) begin
         seen_addr.push_back(data_addr);
         seen_data.push_back(data_wdata);
         dmem[data_addr[9:2]] = data_wdata;
      end
      inst_rdata = imem[inst_addr[9:2]];
      data_rdata = dmem[data_addr[9:2]];
   endtask

   task automatic wait_release();
      step();
      while (!rst_n) begin
         check("inst_ce_o", 32'(inst_ce), 32'd0);
         check("data_ce_o", 32'(data_ce), 32'd0);
         check("data_we_o", 32'(data_we), 32'd0);
         step();
      end
   endtask

   task automatic load_memories();
      int base;
      base = int'(RESET_PC[9:2]);
      for (int i = 0; i < 256; i++) begin
         imem[i] = INSN_NOP;
         dmem[i] = fill_word(i);
      end
      foreach (prog[k]) begin
         imem[base + k] = prog[k];
      end
   endtask

   // ISA-level walk of the program, one instruction at a time
   task automatic run_model();
      word_t regs [32];
      word_t mem [256];
      word_t pc, insn, a, b, res, addr, nxt;
      word_t i_imm, s_imm, b_imm;
      int    steps;
      bit    done;
      exp_addr.delete();
      exp_data.delete();
      for (int i = 0; i < 256; i++) begin
         mem[i] = fill_word(i);
      end
      for (int i = 0; i < 32; i++) begin
         regs[i] = '0;
      end
      pc    = RESET_PC;
      steps = 0;
      do begin
         insn  = imem[pc[9:2]];
         a     = regs[insn[19:15]];
         b     = regs[insn[24:20]];
         i_imm = {{20{insn[31]}}, insn[31:20]};
         s_imm = {{20{insn[31]}}, insn[31:25], insn[11:7]};
         b_imm = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
         nxt   = pc + 32'd4;
         case (insn[6:0])
            OP: begin
               case (insn[14:12])
                  3'b000:  res = insn[30] ? a - b : a + b;
                  3'b100:  res = a ^ b;
                  3'b110:  res = a | b;
                  default: res = a & b;
               endcase
               regs[insn[11:7]] = res;
            end
            OP_IMM: regs[insn[11:7]] = a + i_imm;
            LOAD: begin
               addr = a + i_imm;
               regs[insn[11:7]] = mem[addr[9:2]];
            end
            STORE: begin
               addr = a + s_imm;
               exp_addr.push_back(addr);
               exp_data.push_back(b);
               mem[addr[9:2]] = b;
            end
            BRANCH: begin
               if (a == b) begin
                  nxt = pc + b_imm;
               end
            end
            default: ;
         endcase
         regs[0] = '0;
         done    = (nxt == pc);                      // Reached the self-loop
         pc      = nxt;
         steps++;
      end while (!done && steps < 1000);
      if (!done) begin
         abort_run("Reference model never reached the closing self-loop");
      end
   endtask

   task automatic run_program();
      prog.push_back(b_type(5'd0, 5'd0, 13'd0));
      restart = 1'b1;
      load_memories();
      run_model();
      seen_addr.delete();
      seen_data.delete();
      wait_release();
      restart = 1'b0;
      while (seen_addr.size() < exp_addr.size()) begin
         step();
      end
      repeat (20) step();                            // No stray stores after the last one
      check("store count", 32'(seen_addr.size()), 32'(exp_addr.size()));
      foreach (exp_addr[i]) begin
         check("data_addr_o", seen_addr[i], exp_addr[i]);
         check("data_o", seen_data[i], exp_data[i]);
      end
   endtask

   task automatic check_reset();
      prog.delete();
      prog.push_back(b_type(5'd0, 5'd0, 13'd0));
      load_memories();
      wait_release();
      check("inst_ce_o", 32'(inst_ce), 32'd1);
      check("inst_addr_o", inst_addr, RESET_PC);
   endtask

   task automatic alu_forwarding();
      prog.delete();
      prog.push_back(i_type(OP_IMM, 5'd1, 5'd0, 12'h123));
      prog.push_back(i_type(OP_IMM, 5'd2, 5'd1, 12'hFFB));   // x2 = x1 - 5
      prog.push_back(r_type(ALU_ADD, 5'd3, 5'd1, 5'd2));
      prog.push_back(r_type(ALU_SUB, 5'd4, 5'd3, 5'd2));
      prog.push_back(r_type(ALU_AND, 5'd5, 5'd4, 5'd3));
      prog.push_back(r_type(ALU_OR, 5'd6, 5'd5, 5'd1));
      prog.push_back(r_type(ALU_XOR, 5'd7, 5'd6, 5'd5));
      prog.push_back(s_type(5'd7, 5'd0, 12'h040));            // Store data from EX/MEM
      for (int i = 1; i < 7; i++) begin
         prog.push_back(s_type(5'(i), 5'd0, 12'(12'h040 + 4 * i)));
      end
      run_program();
   endtask

   task automatic load_use();
      prog.delete();
      prog.push_back(i_type(OP_IMM, 5'd1, 5'd0, 12'h2A5));
      prog.push_back(s_type(5'd1, 5'd0, 12'h080));
      prog.push_back(i_type(LOAD, 5'd2, 5'd0, 12'h080));
      prog.push_back(r_type(ALU_ADD, 5'd3, 5'd2, 5'd1));     // Needs the stall
      prog.push_back(s_type(5'd3, 5'd0, 12'h084));
      prog.push_back(i_type(LOAD, 5'd4, 5'd0, 12'h088));     // Fill pattern word
      prog.push_back(s_type(5'd4, 5'd0, 12'h08C));
      run_program();
   endtask

   task automatic branch_skip();
      prog.delete();
      prog.push_back(i_type(OP_IMM, 5'd1, 5'd0, 12'd7));
      prog.push_back(i_type(OP_IMM, 5'd2, 5'd0, 12'd7));
      prog.push_back(b_type(5'd1, 5'd2, 13'd12));            // Taken
      prog.push_back(s_type(5'd1, 5'd0, 12'h0C0));
      prog.push_back(s_type(5'd2, 5'd0, 12'h0C4));
      prog.push_back(i_type(OP_IMM, 5'd3, 5'd0, 12'd9));
      prog.push_back(b_type(5'd1, 5'd3, 13'd12));            // Not taken
      prog.push_back(s_type(5'd1, 5'd0, 12'h0C8));
      prog.push_back(s_type(5'd3, 5'd0, 12'h0CC));
      run_program();
   endtask

   task automatic random_stream();
      word_t     r;
      word_t     insn;
      reg_addr_t rd, rs1, rs2;
      prog.delete();
      for (int i = 1; i < 8; i++) begin
         r = xorshift();
         prog.push_back(i_type(OP_IMM, 5'(i), 5'd0, r[11:0]));
      end
      for (int i = 0; i < 40; i++) begin
         r   = xorshift();
         rd  = pick_reg(r);
         rs1 = pick_reg(r >> 3);
         rs2 = pick_reg(r >> 6);
         case (r[31:29])
            3'd5:    insn = i_type(OP_IMM, rd, rs1, r[22:11]);
            3'd6:    insn = i_type(LOAD, rd, 5'd0, {6'b001000, r[16:13], 2'b00});
            3'd7:    insn = b_type(rs1, rs2, 13'd8);            // Skips one
            default: insn = r_type(alu_op_e'(r[31:29]), rd, rs1, rs2);
         endcase
         prog.push_back(insn);
         if (i % 5 == 4) begin
            r = xorshift();
            prog.push_back(s_type(pick_reg(r), 5'd0, {6'b001000, r[8:5], 2'b00}));
         end
      end
      for (int i = 1; i < 8; i++) begin
         prog.push_back(s_type(5'(i), 5'd0, 12'(12'h300 + 4 * i)));
      end
      run_program();
   endtask

   initial begin
      repeat (NUM_TESTS * 2000) @(posedge clk);
      abort_run("Watchdog expired before all tests finished");
   end

   initial begin
      restart    = 1'b0;
      inst_rdata = INSN_NOP;
      data_rdata = '0;
      check_reset();
      alu_forwarding();
      load_use();
      branch_skip();
      random_stream();
      $display("Test passed");
      $finish;
   end

endmodule

/* src.f */
hw/rv_pkg.sv
hw/rv_fetch.sv
hw/rv_regfile.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_mem_wb.sv
hw/rv_core.sv
dv/rv_clk_gen.sv
dv/rv_core_chk.sv
dv/rv_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module rv_core_tb -f src.f -o rv_core_sim

out=$(./obj_dir/rv_core_sim 2>&1 || true)
echo "$out"

if grep -qx "Test passed" <<< "$out"; then
    exit 0
fi
exit 1
